//--- common/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [63:0] order_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;
    localparam word_t RESET_PC  = 32'h0000_0000;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        wb_sel_e   wb_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t rs1_data;
        word_t rs2_data;
        word_t imm;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t alu_result;
        word_t store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_e   wb_sel;
        word_t     alu_result;
        word_t     load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- common/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

// one memory port, strobe held until the resp pulse
interface mem_port_if
    import rv32i_pkg::*;
();

    word_t  address;
    logic   read;
    logic   write;
    wmask_t wmask;
    word_t  wdata;
    word_t  rdata;
    logic   resp;

    modport core (output address, read, write, wmask, wdata, input rdata, resp);
    modport mem (input address, read, write, wmask, wdata, output rdata, resp);

endinterface

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import rv32i_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o,
    output logic    equal_o
);

    always_comb begin
        case (op_i)
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            // signed compare
            ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_PASS_B: result_o = b_i;
            default:    result_o = a_i + b_i;
        endcase
    end

    // beq and bne
    assign equal_o = (a_i == b_i);

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      wr_en_i,
    input  word_t     wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    // x0 has no storage
    word_t regs_q [31:1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // same-cycle write shows through to the readers
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_i != '0) begin
            rs1_data_o = (wr_en_i && rd_i == rs1_i) ? wdata_i : regs_q[rs1_i];
        end
        if (rs2_i != '0) begin
            rs2_data_o = (wr_en_i && rd_i == rs2_i) ? wdata_i : regs_q[rs2_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
    import rv32i_pkg::*;
(
    input  word_t inst_i,
    output ctrl_t ctrl_o,
    output word_t imm_o,
    output logic  uses_rs2_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // shared funct3 map of OP and OP-IMM, pass-b marks an unsupported code
    function automatic alu_op_e funct3_op(logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_PASS_B;
        endcase
    endfunction

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        ctrl_o.wb_sel = WB_ALU;
        ctrl_o.rs1    = inst_i[19:15];
        ctrl_o.rs2    = inst_i[24:20];
        ctrl_o.rd     = inst_i[11:7];
        imm_o         = {{20{inst_i[31]}}, inst_i[31:20]};
        uses_rs2_o    = 1'b0;
        legal         = 1'b1;

        case (opcode_e'(inst_i[6:0]))
            OP_LUI: begin
                ctrl_o.rs1         = '0;
                ctrl_o.alu_op      = ALU_PASS_B;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                imm_o              = {inst_i[31:12], 12'b0};
            end
            OP_JAL: begin
                ctrl_o.rs1       = '0;
                ctrl_o.jump      = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_sel    = WB_PC4;
                imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            end
            OP_BRANCH: begin
                // only beq and bne
                legal            = (funct3[2:1] == 2'b00);
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = funct3[0];
                ctrl_o.rd        = '0;
                uses_rs2_o       = 1'b1;
                imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            end
            OP_LOAD: begin
                legal              = (funct3 == 3'b010);
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.wb_sel      = WB_LOAD;
            end
            OP_STORE: begin
                legal              = (funct3 == 3'b010);
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.rd          = '0;
                uses_rs2_o         = 1'b1;
                imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            end
            OP_IMM: begin
                legal              = (funct3_op(funct3) != ALU_PASS_B);
                ctrl_o.alu_op      = funct3_op(funct3);
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
            end
            OP_REG: begin
                legal = (funct3_op(funct3) != ALU_PASS_B)
                     && (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
                ctrl_o.alu_op    = funct7[5] ? ALU_SUB : funct3_op(funct3);
                ctrl_o.reg_write = 1'b1;
                uses_rs2_o       = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // anything else travels as a harmless bubble
        if (!legal) begin
            ctrl_o     = '0;
            imm_o      = '0;
            uses_rs2_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hazard_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t id_rs1_i,
    input  reg_addr_t id_rs2_i,
    input  logic      id_uses_rs2_i,
    input  reg_addr_t ex_rd_i,
    input  reg_addr_t mem_rd_i,
    input  reg_addr_t wb_rd_i,
    input  logic      ex_wr_i,
    input  logic      mem_wr_i,
    input  logic      wb_wr_i,
    input  logic      branch_taken_i,
    input  logic      imem_wait_i,
    input  logic      dmem_wait_i,
    input  logic      wb_valid_i,
    output logic      stall_front_o,
    output logic      freeze_o,
    output logic      bubble_ex_o,
    output logic      flush_o,
    output logic      retire_valid_o,
    output order_t    retire_order_o
);

    logic   rs1_busy;
    logic   rs2_busy;
    logic   raw_hazard;
    order_t order_q;

    // x0 never counts as a pending destination
    function automatic logic pending_write(reg_addr_t src, reg_addr_t dst, logic wr);
        return wr && (dst != '0) && (src == dst);
    endfunction

    assign rs1_busy = pending_write(id_rs1_i, ex_rd_i, ex_wr_i)
                   || pending_write(id_rs1_i, mem_rd_i, mem_wr_i)
                   || pending_write(id_rs1_i, wb_rd_i, wb_wr_i);
    assign rs2_busy = pending_write(id_rs2_i, ex_rd_i, ex_wr_i)
                   || pending_write(id_rs2_i, mem_rd_i, mem_wr_i)
                   || pending_write(id_rs2_i, wb_rd_i, wb_wr_i);

    assign raw_hazard = rs1_busy || (id_uses_rs2_i && rs2_busy);

    // any outstanding memory request holds every stage
    assign freeze_o = imem_wait_i || dmem_wait_i;

    // taken branch wins over a decode stall
    assign flush_o       = branch_taken_i;
    assign stall_front_o = raw_hazard && !branch_taken_i;
    assign bubble_ex_o   = raw_hazard;

    assign retire_valid_o = wb_valid_i && !freeze_o;
    assign retire_order_o = order_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            order_q <= '0;
        end else if (retire_valid_o) begin
            order_q <= order_q + 64'd1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pipeline_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline_datapath
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_front_i,
    input  logic      freeze_i,
    input  logic      bubble_ex_i,
    input  logic      flush_i,
    mem_port_if.core  imem,
    mem_port_if.core  dmem,
    output reg_addr_t id_rs1_o,
    output reg_addr_t id_rs2_o,
    output logic      id_uses_rs2_o,
    output reg_addr_t ex_rd_o,
    output reg_addr_t mem_rd_o,
    output reg_addr_t wb_rd_o,
    output logic      ex_wr_o,
    output logic      mem_wr_o,
    output logic      wb_wr_o,
    output logic      branch_taken_o,
    output logic      imem_wait_o,
    output logic      dmem_wait_o,
    output logic      wb_valid_o,
    output word_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_wdata_o
);

    if_id_t  if_id_q;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_q;

    word_t pc_q;
    logic  fetch_en_q;
    word_t ibuf_q;
    logic  ibuf_valid_q;
    logic  inst_avail;
    word_t inst_word;
    logic  fetch_advance;

    ctrl_t id_ctrl;
    word_t id_imm;
    word_t rs1_data;
    word_t rs2_data;

    word_t alu_b;
    word_t alu_result;
    logic  alu_equal;
    word_t branch_target;

    logic  mem_done_q;
    word_t mem_buf_q;
    word_t load_data;

    word_t wb_value;
    logic  wb_write;

    // fetch, read only
    assign imem.read    = fetch_en_q && !ibuf_valid_q;
    assign imem.address = pc_q;
    assign imem.write   = 1'b0;
    assign imem.wmask   = '0;
    assign imem.wdata   = '0;
    assign imem_wait_o  = imem.read && !imem.resp;

    assign inst_avail    = ibuf_valid_q || (imem.read && imem.resp);
    assign inst_word     = ibuf_valid_q ? ibuf_q : imem.rdata;
    assign fetch_advance = !freeze_i && !stall_front_i && inst_avail;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fetch_en_q   <= 1'b0;
            pc_q         <= RESET_PC;
            ibuf_valid_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if (!freeze_i && flush_i) begin
                pc_q         <= branch_target;
                ibuf_valid_q <= 1'b0;
            end else if (fetch_advance) begin
                pc_q         <= pc_q + 32'd4;
                ibuf_valid_q <= 1'b0;
            end else if (imem.read && imem.resp) begin
                ibuf_valid_q <= 1'b1;
            end
        end
    end

    // word that arrived while IF/ID could not take it
    always_ff @(posedge clk_i) begin
        if (imem.read && imem.resp) begin
            ibuf_q <= imem.rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            if_id_q <= '{valid: 1'b0, pc: RESET_PC, inst: NOP_INSTR};
        end else if (!freeze_i) begin
            if (flush_i || (!stall_front_i && !inst_avail)) begin
                if_id_q <= '{valid: 1'b0, pc: pc_q, inst: NOP_INSTR};
            end else if (!stall_front_i) begin
                if_id_q <= '{valid: 1'b1, pc: pc_q, inst: inst_word};
            end
        end
    end

    // decode
    inst_decoder decoder_i (
        .inst_i     (if_id_q.inst),
        .ctrl_o     (id_ctrl),
        .imm_o      (id_imm),
        .uses_rs2_o (id_uses_rs2_o)
    );

    regfile regfile_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (id_ctrl.rs1),
        .rs2_i      (id_ctrl.rs2),
        .rd_i       (mem_wb_q.rd),
        .wr_en_i    (wb_write),
        .wdata_i    (wb_value),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign id_rs1_o = id_ctrl.rs1;
    assign id_rs2_o = id_ctrl.rs2;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_q <= '0;
        end else if (!freeze_i) begin
            if (flush_i || bubble_ex_i) begin
                id_ex_q <= '0;
            end else begin
                id_ex_q.valid    <= if_id_q.valid;
                id_ex_q.pc       <= if_id_q.pc;
                id_ex_q.ctrl     <= id_ctrl;
                id_ex_q.rs1_data <= rs1_data;
                id_ex_q.rs2_data <= rs2_data;
                id_ex_q.imm      <= id_imm;
            end
        end
    end

    // execute, branch resolved here
    assign alu_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : id_ex_q.rs2_data;

    alu alu_i (
        .op_i     (id_ex_q.ctrl.alu_op),
        .a_i      (id_ex_q.rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result),
        .equal_o  (alu_equal)
    );

    assign branch_target  = id_ex_q.pc + id_ex_q.imm;
    assign branch_taken_o = id_ex_q.valid && (id_ex_q.ctrl.jump
                         || (id_ex_q.ctrl.branch && (alu_equal != id_ex_q.ctrl.branch_ne)));
    assign ex_rd_o = id_ex_q.ctrl.rd;
    assign ex_wr_o = id_ex_q.valid && id_ex_q.ctrl.reg_write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_q <= '0;
        end else if (!freeze_i) begin
            ex_mem_q.valid      <= id_ex_q.valid;
            ex_mem_q.pc         <= id_ex_q.pc;
            ex_mem_q.ctrl       <= id_ex_q.ctrl;
            ex_mem_q.alu_result <= alu_result;
            ex_mem_q.store_data <= id_ex_q.rs2_data;
        end
    end

    // memory, request dropped once answered so it is never repeated
    assign dmem.read    = ex_mem_q.valid && ex_mem_q.ctrl.mem_read && !mem_done_q;
    assign dmem.write   = ex_mem_q.valid && ex_mem_q.ctrl.mem_write && !mem_done_q;
    assign dmem.address = ex_mem_q.alu_result;
    assign dmem.wdata   = ex_mem_q.store_data;
    assign dmem.wmask   = ex_mem_q.ctrl.mem_write ? 4'b1111 : 4'b0000;
    assign dmem_wait_o  = (dmem.read || dmem.write) && !dmem.resp;
    assign load_data    = mem_done_q ? mem_buf_q : dmem.rdata;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_done_q <= 1'b0;
        end else if (!freeze_i) begin
            mem_done_q <= 1'b0;
        end else if ((dmem.read || dmem.write) && dmem.resp) begin
            mem_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dmem.read && dmem.resp) begin
            mem_buf_q <= dmem.rdata;
        end
    end

    assign mem_rd_o = ex_mem_q.ctrl.rd;
    assign mem_wr_o = ex_mem_q.valid && ex_mem_q.ctrl.reg_write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_wb_q <= '0;
        end else if (!freeze_i) begin
            mem_wb_q.valid      <= ex_mem_q.valid;
            mem_wb_q.pc         <= ex_mem_q.pc;
            mem_wb_q.rd         <= ex_mem_q.ctrl.rd;
            mem_wb_q.reg_write  <= ex_mem_q.ctrl.reg_write;
            mem_wb_q.wb_sel     <= ex_mem_q.ctrl.wb_sel;
            mem_wb_q.alu_result <= ex_mem_q.alu_result;
            mem_wb_q.load_data  <= load_data;
        end
    end

    // writeback
    always_comb begin
        case (mem_wb_q.wb_sel)
            WB_LOAD: wb_value = mem_wb_q.load_data;
            WB_PC4:  wb_value = mem_wb_q.pc + 32'd4;
            default: wb_value = mem_wb_q.alu_result;
        endcase
    end

    // write lands on the cycle the instruction leaves WB
    assign wb_write = mem_wb_q.valid && mem_wb_q.reg_write && !freeze_i;
    assign wb_rd_o  = mem_wb_q.rd;
    assign wb_wr_o  = mem_wb_q.valid && mem_wb_q.reg_write;

    assign wb_valid_o     = mem_wb_q.valid;
    assign retire_pc_o    = mem_wb_q.pc;
    assign retire_rd_o    = mem_wb_q.rd;
    assign retire_wdata_o = (mem_wb_q.reg_write && mem_wb_q.rd != '0) ? wb_value : '0;

endmodule

`default_nettype wire

//--- rtl/rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    output word_t     imem_addr_o,
    output logic      imem_read_o,
    input  word_t     imem_rdata_i,
    input  logic      imem_resp_i,

    output word_t     dmem_addr_o,
    output logic      dmem_read_o,
    output logic      dmem_write_o,
    output wmask_t    dmem_wmask_o,
    output word_t     dmem_wdata_o,
    input  word_t     dmem_rdata_i,
    input  logic      dmem_resp_i,

    output logic      retire_valid_o,
    output order_t    retire_order_o,
    output word_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_wdata_o
);

    mem_port_if imem_if ();
    mem_port_if dmem_if ();

    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    logic      id_uses_rs2;
    reg_addr_t ex_rd;
    reg_addr_t mem_rd;
    reg_addr_t wb_rd;
    logic      ex_wr;
    logic      mem_wr;
    logic      wb_wr;
    logic      branch_taken;
    logic      imem_wait;
    logic      dmem_wait;
    logic      wb_valid;
    logic      stall_front;
    logic      freeze;
    logic      bubble_ex;
    logic      flush;

    // memory side of both ports
    assign imem_addr_o   = imem_if.address;
    assign imem_read_o   = imem_if.read;
    assign imem_if.rdata = imem_rdata_i;
    assign imem_if.resp  = imem_resp_i;

    assign dmem_addr_o   = dmem_if.address;
    assign dmem_read_o   = dmem_if.read;
    assign dmem_write_o  = dmem_if.write;
    assign dmem_wmask_o  = dmem_if.wmask;
    assign dmem_wdata_o  = dmem_if.wdata;
    assign dmem_if.rdata = dmem_rdata_i;
    assign dmem_if.resp  = dmem_resp_i;

    hazard_ctrl hazard_ctrl_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .id_rs1_i       (id_rs1),
        .id_rs2_i       (id_rs2),
        .id_uses_rs2_i  (id_uses_rs2),
        .ex_rd_i        (ex_rd),
        .mem_rd_i       (mem_rd),
        .wb_rd_i        (wb_rd),
        .ex_wr_i        (ex_wr),
        .mem_wr_i       (mem_wr),
        .wb_wr_i        (wb_wr),
        .branch_taken_i (branch_taken),
        .imem_wait_i    (imem_wait),
        .dmem_wait_i    (dmem_wait),
        .wb_valid_i     (wb_valid),
        .stall_front_o  (stall_front),
        .freeze_o       (freeze),
        .bubble_ex_o    (bubble_ex),
        .flush_o        (flush),
        .retire_valid_o (retire_valid_o),
        .retire_order_o (retire_order_o)
    );

    pipeline_datapath datapath_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_front_i  (stall_front),
        .freeze_i       (freeze),
        .bubble_ex_i    (bubble_ex),
        .flush_i        (flush),
        .imem           (imem_if.core),
        .dmem           (dmem_if.core),
        .id_rs1_o       (id_rs1),
        .id_rs2_o       (id_rs2),
        .id_uses_rs2_o  (id_uses_rs2),
        .ex_rd_o        (ex_rd),
        .mem_rd_o       (mem_rd),
        .wb_rd_o        (wb_rd),
        .ex_wr_o        (ex_wr),
        .mem_wr_o       (mem_wr),
        .wb_wr_o        (wb_wr),
        .branch_taken_o (branch_taken),
        .imem_wait_o    (imem_wait),
        .dmem_wait_o    (dmem_wait),
        .wb_valid_o     (wb_valid),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

`default_nettype wire

//--- testbench/rv32i_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_properties
    import rv32i_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  word_t  imem_addr_i,
    input  logic   imem_read_i,
    input  logic   imem_resp_i,
    input  word_t  dmem_addr_i,
    input  logic   dmem_read_i,
    input  logic   dmem_write_i,
    input  wmask_t dmem_wmask_i,
    input  word_t  dmem_wdata_i,
    input  logic   dmem_resp_i,
    input  logic   retire_valid_i
);

    int failures = 0;

    // fetch held on the same address until resp
    imem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_read_i && !imem_resp_i |=> imem_read_i && $stable(imem_addr_i))
    else begin
        $error("imem request changed before its response");
        failures++;
    end

    dmem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (dmem_read_i || dmem_write_i) && !dmem_resp_i
        |=> $stable({dmem_read_i, dmem_write_i, dmem_addr_i, dmem_wmask_i, dmem_wdata_i}))
    else begin
        $error("dmem request changed before its response");
        failures++;
    end

    dmem_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(dmem_read_i && dmem_write_i))
    else begin
        $error("dmem read and write high together");
        failures++;
    end

    // one reset edge clears the pipeline
    retire_in_reset: assert property (@(posedge clk_i)
        rst_i |=> !rst_i || !retire_valid_i)
    else begin
        $error("retire_valid_o high during reset");
        failures++;
    end

endmodule

bind rv32i_core rv32i_core_properties properties_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .imem_addr_i    (imem_addr_o),
    .imem_read_i    (imem_read_o),
    .imem_resp_i    (imem_resp_i),
    .dmem_addr_i    (dmem_addr_o),
    .dmem_read_i    (dmem_read_o),
    .dmem_write_i   (dmem_write_o),
    .dmem_wmask_i   (dmem_wmask_o),
    .dmem_wdata_i   (dmem_wdata_o),
    .dmem_resp_i    (dmem_resp_i),
    .retire_valid_i (retire_valid_o)
);

`default_nettype wire

//--- testbench/tb_rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core
    import rv32i_pkg::*;
();

    localparam int DATA_WORDS = 128;
    localparam int DMEM_WORDS = 256;
    localparam int HDR        = 3;

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    logic      imem_read;
    word_t     imem_rdata;
    logic      imem_resp;
    word_t     dmem_addr;
    logic      dmem_read;
    logic      dmem_write;
    wmask_t    dmem_wmask;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      dmem_resp;
    logic      retire_valid;
    order_t    retire_order;
    word_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_wdata;

    word_t       tdata [0:DATA_WORDS-1];
    word_t       dmem_data [0:DMEM_WORDS-1];
    int          n_prog;
    int          n_retire;
    int          n_store;
    int          retired;
    int          stores_seen;
    int          cycles;
    int          cycle_limit;
    logic [15:0] lfsr_q;
    logic        imem_busy;
    logic        dmem_busy;
    int unsigned imem_delay;
    int unsigned dmem_delay;

    rv32i_core rv32i_core_i (
        .clk_i          (clk),
        .rst_i          (rst),
        .imem_addr_o    (imem_addr),
        .imem_read_o    (imem_read),
        .imem_rdata_i   (imem_rdata),
        .imem_resp_i    (imem_resp),
        .dmem_addr_o    (dmem_addr),
        .dmem_read_o    (dmem_read),
        .dmem_write_o   (dmem_write),
        .dmem_wmask_o   (dmem_wmask),
        .dmem_wdata_o   (dmem_wdata),
        .dmem_rdata_i   (dmem_rdata),
        .dmem_resp_i    (dmem_resp),
        .retire_valid_o (retire_valid),
        .retire_order_o (retire_order),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wdata_o (retire_wdata)
    );

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // two LFSR bits give a delay of 0 to 3 cycles
    task automatic draw_delay(output int unsigned delay);
        logic [1:0] bits;
        bits[0] = lfsr_q[0];
        lfsr_q  = lfsr_next(lfsr_q);
        bits[1] = lfsr_q[0];
        lfsr_q  = lfsr_next(lfsr_q);
        delay   = bits;
    endtask

    // past the program the fetch sees nops
    task automatic serve_fetch();
        int unsigned index;
        index = imem_addr[31:2];
        if (imem_addr[1:0] != 2'b00) begin
            report_error("instruction fetch from a misaligned address");
        end
        imem_rdata = (index < n_prog) ? tdata[HDR + index] : NOP_INSTR;
    endtask

    task automatic serve_data();
        int unsigned index;
        int          base;
        index = dmem_addr[31:2];
        if (dmem_addr[1:0] != 2'b00 || index >= DMEM_WORDS) begin
            report_error("data access outside the data memory");
        end
        if (dmem_write) begin
            if (stores_seen >= n_store) begin
                report_error("the core stored more words than the program writes");
            end
            base = HDR + n_prog + 3 * n_retire + 2 * stores_seen;
            check_value("dmem_addr_o", dmem_addr, tdata[base]);
            check_value("dmem_wdata_o", dmem_wdata, tdata[base + 1]);
            check_value("dmem_wmask_o", dmem_wmask, 4'b1111);
            dmem_data[index] = dmem_wdata;
            stores_seen      = stores_seen + 1;
        end else begin
            dmem_rdata = dmem_data[index];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int i;
        rst         = 1'b1;
        imem_rdata  = '0;
        imem_resp   = 1'b0;
        dmem_rdata  = '0;
        dmem_resp   = 1'b0;
        imem_busy   = 1'b0;
        dmem_busy   = 1'b0;
        imem_delay  = 0;
        dmem_delay  = 0;
        lfsr_q      = 16'd83;
        retired     = 0;
        stores_seen = 0;
        cycles      = 0;
        cycle_limit = 1000;
        $readmemh("testbench/rv32i_core_testdata.hex", tdata);
        if ($isunknown({tdata[0], tdata[1], tdata[2]})) begin
            report_error("the test data file is missing or has no counts");
        end
        n_prog      = tdata[0];
        n_retire    = tdata[1];
        n_store     = tdata[2];
        if (HDR + n_prog + 3 * n_retire + 2 * n_store > DATA_WORDS) begin
            report_error("the test data file is longer than its array");
        end
        // five stages, each slowed by at most four cycles of memory wait
        cycle_limit = n_retire * 5 * 4 + 100;
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem_data[i] = (i * 4) ^ 32'h5A5A_A5A5 ^ {16'(i * 4), 16'((i * 4) >> 16)};
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        wait (retired == n_retire);
        @(negedge clk);
        if (stores_seen != n_store) begin
            report_error("fewer stores than expected by the end of the program");
        end else if (rv32i_core_i.properties_i.failures != 0) begin
            report_error("an assertion on the DUT ports failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // memory models answer on the falling edge
    always @(negedge clk) begin
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (rst) begin
            imem_busy = 1'b0;
            dmem_busy = 1'b0;
        end else begin
            if (imem_read) begin
                if (!imem_busy) begin
                    imem_busy = 1'b1;
                    draw_delay(imem_delay);
                end
                if (imem_delay == 0) begin
                    imem_busy = 1'b0;
                    imem_resp = 1'b1;
                    serve_fetch();
                end else begin
                    imem_delay = imem_delay - 1;
                end
            end
            if (dmem_read || dmem_write) begin
                if (!dmem_busy) begin
                    dmem_busy = 1'b1;
                    draw_delay(dmem_delay);
                end
                if (dmem_delay == 0) begin
                    dmem_busy = 1'b0;
                    dmem_resp = 1'b1;
                    serve_data();
                end else begin
                    dmem_delay = dmem_delay - 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            report_error($sformatf("timeout after %0d cycles with %0d of %0d instructions retired",
                                   cycles, retired, n_retire));
        end
        if (rv32i_core_i.properties_i.failures != 0) begin
            report_error("an assertion on the DUT ports failed");
        end
    end

    // retirement trace in program order
    always @(posedge clk) begin
        int base;
        if (!rst && retire_valid && retired < n_retire) begin
            base = HDR + n_prog + 3 * retired;
            check_value("retire_order_o", retire_order, 64'(retired));
            check_value("retire_pc_o", retire_pc, tdata[base]);
            check_value("retire_rd_o", retire_rd, tdata[base + 1]);
            check_value("retire_wdata_o", retire_wdata, tdata[base + 2]);
            retired = retired + 1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/rv32i_core_testdata.hex
// counts: program words, retirement records, store records
// then program words, retirement records (pc rd value), store records (address data)
0000001B 00000016 00000002
// program from address 0, four words per line
123450B7 FFB00113 00710193 00012213
6780E293 0F02F313 FFF34393 00328433
402184B3 0072F533 003365B3 0034C633
003126B3 10802023 10002703 00170013
00E007B3 00D20663 06300813 06200813
00919663 06100913 06000913 008008EF
05F00A13 11102223 0000006F
// retirements: pc rd value
00000000 00000001 12345000
00000004 00000002 FFFFFFFB
00000008 00000003 00000002
0000000C 00000004 00000001
00000010 00000005 12345678
00000014 00000006 00000070
00000018 00000007 FFFFFF8F
0000001C 00000008 1234567A
00000020 00000009 00000007
00000024 0000000A 12345608
00000028 0000000B 00000072
0000002C 0000000C 00000005
00000030 0000000D 00000001
00000034 00000000 00000000
00000038 0000000E 1234567A
0000003C 00000000 00000000
00000040 0000000F 1234567A
00000044 00000000 00000000
00000050 00000000 00000000
0000005C 00000011 00000060
00000064 00000000 00000000
00000068 00000000 00000000
// stores: address data
00000100 1234567A
00000104 00000060

//--- rv32i_core.f
common/rv32i_pkg.sv
common/mem_port_if.sv
rtl/alu.sv
rtl/regfile.sv
rtl/inst_decoder.sv
rtl/hazard_ctrl.sv
rtl/pipeline_datapath.sv
rtl/rv32i_core.sv
testbench/rv32i_core_properties.sv
testbench/tb_rv32i_core.sv
